/* common/usb_defs.svh */
`ifndef USB_DEFS_SVH
`define USB_DEFS_SVH

// Function address the token must carry
`define USB_DEV_ADDR 7'h05

// Bulk endpoint used by both OUT and IN
`define USB_EP_NUM 4'h1

// Payload bytes the loopback buffer can hold
`define USB_BUF_DEPTH 64
`define USB_CNT_W $clog2(`USB_BUF_DEPTH + 1)

`endif

/* common/usb_pkg.sv */
package usb_pkg;

  // PID byte as it appears on the wire, check nibble in the top half
  typedef enum logic [7:0] {
    PID_OUT   = 8'hE1,
    PID_IN    = 8'h69,
    PID_DATA0 = 8'hC3,
    PID_DATA1 = 8'h4B,
    PID_ACK   = 8'hD2,
    PID_NAK   = 8'h5A
  } usb_pid_e;

  // What the transmit side is asked to send
  typedef enum logic [1:0] {
    RESP_NONE = 2'd0,
    RESP_ACK  = 2'd1,
    RESP_NAK  = 2'd2,
    RESP_DATA = 2'd3
  } usb_resp_e;

  localparam logic [15:0] CRC16_INIT      = 16'hFFFF;
  localparam logic [15:0] CRC16_POLY_REFL = 16'hA001;  // x^16 + x^15 + x^2 + 1, LSB first
  localparam logic [15:0] CRC16_RESIDUAL  = 16'hB001;  // Remainder over payload plus CRC

endpackage

/* logic/usb_crc16.sv */
`timescale 1ns/1ps
module usb_crc16 import usb_pkg::*; (
  input  logic        clock_i,
  input  logic        arst_n_i,
  input  logic        clear_i,
  input  logic        en_i,
  input  logic [7:0]  data_i,
  output logic [15:0] crc_o
);

  logic [15:0] crc_q;

  // Eight LSB-first shifts of the reflected register
  function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic [7:0] din);
    logic [15:0] r;
    r = crc ^ {8'h00, din};
    for (int i = 0; i < 8; i++) begin
      r = r[0] ? ((r >> 1) ^ CRC16_POLY_REFL) : (r >> 1);
    end
    return r;
  endfunction

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      crc_q <= CRC16_INIT;
    end else if (clear_i) begin
      crc_q <= CRC16_INIT;
    end else if (en_i) begin
      crc_q <= crc_step(crc_q, data_i);
    end
  end

  assign crc_o = crc_q;

endmodule

/* decode/usb_pkt_decode.sv */
`timescale 1ns/1ps
`include "usb_defs.svh"
module usb_pkt_decode import usb_pkg::*; (
  input  logic       clock_i,
  input  logic       arst_n_i,
  input  logic       rx_tvalid_i,
  input  logic       rx_tlast_i,
  input  logic [7:0] rx_tdata_i,
  input  logic       busy_i,
  output logic       rx_tready_o,
  output logic       tok_out_o,
  output logic       tok_in_o,
  output logic       tok_ack_o,
  output logic       data_end_o,
  output logic       data_pid1_o,
  output logic       crc_ok_o,
  output logic       byte_we_o,
  output logic [7:0] byte_o
);

  typedef enum logic [2:0] {S_PID, S_TOK1, S_TOK2, S_DATA, S_SKIP} state_e;

  state_e      state_q;
  logic        take;
  logic        pid_ok;
  logic        tok_in_q;   // Token was IN rather than OUT
  logic [7:0]  tok_b1_q;
  logic        tok_match;
  logic [15:0] crc_w;

  assign rx_tready_o = ~busy_i;  // Host waits while a response is in flight
  assign take        = rx_tvalid_i & rx_tready_o;
  assign pid_ok      = (rx_tdata_i[7:4] == ~rx_tdata_i[3:0]);
  // Address sits in the first byte, endpoint straddles both
  assign tok_match   = (tok_b1_q[6:0] == `USB_DEV_ADDR) &&
                       ({rx_tdata_i[2:0], tok_b1_q[7]} == `USB_EP_NUM);
  assign crc_ok_o    = (crc_w == CRC16_RESIDUAL);

  usb_crc16 i_crc16 (
    .clock_i (clock_i),
    .arst_n_i(arst_n_i),
    .clear_i (state_q == S_PID),
    .en_i    (take && state_q == S_DATA),
    .data_i  (rx_tdata_i),
    .crc_o   (crc_w)
  );

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= S_PID;
      tok_in_q    <= 1'b0;
      tok_out_o   <= 1'b0;
      tok_in_o    <= 1'b0;
      tok_ack_o   <= 1'b0;
      data_end_o  <= 1'b0;
      data_pid1_o <= 1'b0;
      byte_we_o   <= 1'b0;
    end else begin
      tok_out_o  <= 1'b0;
      tok_in_o   <= 1'b0;
      tok_ack_o  <= 1'b0;
      data_end_o <= 1'b0;
      byte_we_o  <= 1'b0;
      if (take) begin
        case (state_q)
          S_PID: begin
            if (!pid_ok) begin
              state_q <= rx_tlast_i ? S_PID : S_SKIP;
            end else if (rx_tlast_i) begin
              tok_ack_o <= (rx_tdata_i == PID_ACK);  // Handshake has no address
            end else begin
              case (rx_tdata_i)
                PID_OUT, PID_IN: begin
                  tok_in_q <= (rx_tdata_i == PID_IN);
                  state_q  <= S_TOK1;
                end
                PID_DATA0, PID_DATA1: begin
                  data_pid1_o <= (rx_tdata_i == PID_DATA1);
                  state_q     <= S_DATA;
                end
                default: state_q <= S_SKIP;
              endcase
            end
          end
          S_TOK1: state_q <= rx_tlast_i ? S_PID : S_TOK2;  // Short token is dropped
          S_TOK2: begin
            if (rx_tlast_i) begin
              tok_out_o <= tok_match & ~tok_in_q;
              tok_in_o  <= tok_match & tok_in_q;
              state_q   <= S_PID;
            end else begin
              state_q <= S_SKIP;
            end
          end
          S_DATA: begin
            byte_we_o <= 1'b1;  // CRC bytes go to the buffer too
            if (rx_tlast_i) begin
              data_end_o <= 1'b1;
              state_q    <= S_PID;
            end
          end
          default: state_q <= rx_tlast_i ? S_PID : S_SKIP;
        endcase
      end
    end
  end

  // Token byte and payload byte path
  always_ff @(posedge clock_i) begin
    if (take && state_q == S_TOK1) begin
      tok_b1_q <= rx_tdata_i;
    end
    byte_o <= rx_tdata_i;
  end

endmodule

/* execute/usb_ep_ctrl.sv */
`timescale 1ns/1ps
`include "usb_defs.svh"
module usb_ep_ctrl import usb_pkg::*; (
  input  logic                  clock_i,
  input  logic                  arst_n_i,
  input  logic                  tok_out_i,
  input  logic                  tok_in_i,
  input  logic                  tok_ack_i,
  input  logic                  data_end_i,
  input  logic                  data_pid1_i,
  input  logic                  crc_ok_i,
  input  logic [`USB_CNT_W-1:0] buf_count_i,
  input  logic                  resp_done_i,
  output logic                  buf_commit_o,
  output logic                  buf_rewind_o,
  output logic                  buf_rd_rst_o,
  output usb_resp_e             resp_o,
  output logic                  resp_vld_o,
  output logic                  data_pid1_o,
  output logic                  busy_o
);

  typedef enum logic [1:0] {C_IDLE, C_WAIT_DATA, C_RESP} state_e;

  state_e state_q;
  logic   out_tog_q;   // DATA PID expected on the next OUT
  logic   in_tog_q;    // DATA PID for the held packet
  logic   in_sent_q;   // Data went out, waiting on host ACK
  logic   buf_empty;

  assign buf_empty   = (buf_count_i == '0);
  assign resp_vld_o  = (state_q == C_RESP);
  assign busy_o      = (state_q == C_RESP);
  assign data_pid1_o = in_tog_q;

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= C_IDLE;
      out_tog_q    <= 1'b0;
      in_tog_q     <= 1'b0;
      in_sent_q    <= 1'b0;
      resp_o       <= RESP_NONE;
      buf_commit_o <= 1'b0;
      buf_rewind_o <= 1'b0;
      buf_rd_rst_o <= 1'b0;
    end else begin
      buf_commit_o <= 1'b0;
      buf_rewind_o <= 1'b0;
      buf_rd_rst_o <= 1'b0;
      case (state_q)
        C_IDLE: begin
          if (tok_out_i) begin
            in_sent_q <= 1'b0;
            state_q   <= C_WAIT_DATA;
          end else if (tok_in_i) begin
            resp_o       <= buf_empty ? RESP_NAK : RESP_DATA;
            in_sent_q    <= ~buf_empty;
            buf_rd_rst_o <= 1'b1;  // Every IN replays from byte 0
            state_q      <= C_RESP;
          end else if (tok_ack_i && in_sent_q) begin
            in_tog_q     <= ~in_tog_q;
            in_sent_q    <= 1'b0;
            buf_rewind_o <= 1'b1;  // Host has the data so free the buffer
          end else if (data_end_i) begin
            buf_rewind_o <= buf_empty;  // Data packet without an OUT
          end
        end
        C_WAIT_DATA: begin
          if (data_end_i) begin
            state_q <= C_RESP;
            if (!crc_ok_i) begin
              buf_rewind_o <= buf_empty;
              state_q      <= C_IDLE;  // Corrupt packet gets no answer
            end else if (data_pid1_i != out_tog_q) begin
              resp_o       <= RESP_ACK;  // Host retry of a packet already taken
              buf_rewind_o <= buf_empty;
            end else if (!buf_empty) begin
              resp_o <= RESP_NAK;
            end else begin
              resp_o       <= RESP_ACK;
              buf_commit_o <= 1'b1;
              out_tog_q    <= ~out_tog_q;
            end
          end else if (tok_out_i || tok_in_i) begin
            state_q <= C_IDLE;
          end
        end
        default: begin
          if (resp_done_i) begin
            state_q <= C_IDLE;
          end
        end
      endcase
    end
  end

endmodule

/* logic/usb_pkt_buffer.sv */
`timescale 1ns/1ps
`include "usb_defs.svh"
module usb_pkt_buffer (
  input  logic                  clock_i,
  input  logic                  arst_n_i,
  input  logic                  we_i,
  input  logic [7:0]            data_i,
  input  logic                  commit_i,
  input  logic                  rewind_i,
  input  logic                  rd_i,
  input  logic                  rd_rst_i,
  output logic                  empty_o,
  output logic [`USB_CNT_W-1:0] count_o,
  output logic [7:0]            data_o
);

  localparam int DEPTH = `USB_BUF_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int CNT_W = `USB_CNT_W;
  localparam int WR_W  = $clog2(DEPTH + 4);  // Payload, two CRC bytes and one overflow step

  logic [7:0]            mem_q [DEPTH];
  logic [WR_W-1:0]       wr_cnt_q;  // Tentative bytes of the packet in flight
  logic [`USB_CNT_W-1:0] count_q;   // Committed payload length
  logic [AW-1:0]         rd_ptr_q;
  logic                  wr_ok;

  // A held packet blocks writes until the host has it
  assign wr_ok   = we_i && (count_q == '0) && (wr_cnt_q != WR_W'(DEPTH + 3));
  assign empty_o = (count_q == '0);
  assign count_o = count_q;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clock_i) begin
    if (wr_ok && wr_cnt_q < WR_W'(DEPTH)) begin
      mem_q[wr_cnt_q[AW-1:0]] <= data_i;
    end
  end

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_cnt_q <= '0;
      count_q  <= '0;
      rd_ptr_q <= '0;
    end else if (rewind_i) begin
      wr_cnt_q <= '0;  // Drops tentative bytes and any held packet
      count_q  <= '0;
      rd_ptr_q <= '0;
    end else if (commit_i) begin
      wr_cnt_q <= '0;
      rd_ptr_q <= '0;
      if (wr_cnt_q >= WR_W'(2) && wr_cnt_q <= WR_W'(DEPTH + 2)) begin
        count_q <= CNT_W'(wr_cnt_q - WR_W'(2));  // Strip the CRC
      end else begin
        count_q <= '0;  // Overflowed packet refused
      end
    end else begin
      if (wr_ok) begin
        wr_cnt_q <= wr_cnt_q + 1'b1;
      end
      if (rd_rst_i) begin
        rd_ptr_q <= '0;
      end else if (rd_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

endmodule

/* result/usb_tx_build.sv */
`timescale 1ns/1ps
`include "usb_defs.svh"
module usb_tx_build import usb_pkg::*; (
  input  logic                  clock_i,
  input  logic                  arst_n_i,
  input  usb_resp_e             resp_i,
  input  logic                  resp_vld_i,
  input  logic                  data_pid1_i,
  input  logic [`USB_CNT_W-1:0] buf_count_i,
  input  logic [7:0]            buf_data_i,
  input  logic                  tx_tready_i,
  output logic                  buf_rd_o,
  output logic                  resp_done_o,
  output logic                  tx_tvalid_o,
  output logic                  tx_tlast_o,
  output logic [7:0]            tx_tdata_o
);

  typedef enum logic [2:0] {B_IDLE, B_PID, B_PAY, B_CRCL, B_CRCH} state_e;

  state_e                state_q;
  logic [`USB_CNT_W-1:0] sent_q;  // Payload bytes accepted so far
  logic                  take;
  logic [7:0]            pid_byte;
  logic [15:0]           crc_w;

  assign tx_tvalid_o = (state_q != B_IDLE);
  assign take        = tx_tvalid_o & tx_tready_i;
  assign buf_rd_o    = take && (state_q == B_PAY);
  // Handshakes are a lone PID byte
  assign tx_tlast_o  = (state_q == B_CRCH) || (state_q == B_PID && resp_i != RESP_DATA);
  assign resp_done_o = take & tx_tlast_o;

  always_comb begin
    case (resp_i)
      RESP_ACK: pid_byte = PID_ACK;
      RESP_NAK: pid_byte = PID_NAK;
      default:  pid_byte = data_pid1_i ? PID_DATA1 : PID_DATA0;
    endcase
  end

  always_comb begin
    case (state_q)
      B_PAY:   tx_tdata_o = buf_data_i;
      B_CRCL:  tx_tdata_o = ~crc_w[7:0];   // CRC is sent inverted, low byte first
      B_CRCH:  tx_tdata_o = ~crc_w[15:8];
      default: tx_tdata_o = pid_byte;
    endcase
  end

  usb_crc16 i_crc16 (
    .clock_i (clock_i),
    .arst_n_i(arst_n_i),
    .clear_i (state_q == B_IDLE),
    .en_i    (buf_rd_o),
    .data_i  (buf_data_i),
    .crc_o   (crc_w)
  );

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= B_IDLE;
      sent_q  <= '0;
    end else begin
      case (state_q)
        B_IDLE: begin
          sent_q <= '0;
          if (resp_vld_i) begin
            state_q <= B_PID;
          end
        end
        B_PID: begin
          if (take) begin
            if (resp_i != RESP_DATA) begin
              state_q <= B_IDLE;
            end else begin
              state_q <= (buf_count_i == '0) ? B_CRCL : B_PAY;  // Zero-length packet
            end
          end
        end
        B_PAY: begin
          if (take) begin
            sent_q <= sent_q + 1'b1;
            if (sent_q + 1'b1 == buf_count_i) begin
              state_q <= B_CRCL;
            end
          end
        end
        B_CRCL: state_q <= take ? B_CRCH : B_CRCL;
        default: state_q <= take ? B_IDLE : B_CRCH;
      endcase
    end
  end

endmodule

/* logic/usb_bulk_top.sv */
`timescale 1ns/1ps
`include "usb_defs.svh"
module usb_bulk_top import usb_pkg::*; (
  input  logic       clock_i,
  input  logic       arst_n_i,
  input  logic       rx_tvalid_i,
  input  logic       rx_tlast_i,
  input  logic [7:0] rx_tdata_i,
  output logic       rx_tready_o,
  output logic       tx_tvalid_o,
  output logic       tx_tlast_o,
  output logic [7:0] tx_tdata_o,
  input  logic       tx_tready_i
);

  logic                  tok_out, tok_in, tok_ack;
  logic                  data_end, rx_pid1, crc_ok, busy;
  logic                  byte_we;
  logic [7:0]            rx_byte;
  logic                  buf_commit, buf_rewind, buf_rd_rst, buf_rd;
  logic [`USB_CNT_W-1:0] buf_count;
  logic [7:0]            buf_data;
  usb_resp_e             resp;
  logic                  resp_vld, resp_done, tx_pid1;

  usb_pkt_decode i_usb_pkt_decode (
    .clock_i    (clock_i),     .arst_n_i   (arst_n_i),
    .rx_tvalid_i(rx_tvalid_i), .rx_tlast_i (rx_tlast_i),
    .rx_tdata_i (rx_tdata_i),  .busy_i     (busy),
    .rx_tready_o(rx_tready_o), .tok_out_o  (tok_out),
    .tok_in_o   (tok_in),      .tok_ack_o  (tok_ack),
    .data_end_o (data_end),    .data_pid1_o(rx_pid1),
    .crc_ok_o   (crc_ok),      .byte_we_o  (byte_we),
    .byte_o     (rx_byte)
  );

  usb_ep_ctrl i_usb_ep_ctrl (
    .clock_i     (clock_i),    .arst_n_i    (arst_n_i),
    .tok_out_i   (tok_out),    .tok_in_i    (tok_in),
    .tok_ack_i   (tok_ack),    .data_end_i  (data_end),
    .data_pid1_i (rx_pid1),    .crc_ok_i    (crc_ok),
    .buf_count_i (buf_count),  .resp_done_i (resp_done),
    .buf_commit_o(buf_commit), .buf_rewind_o(buf_rewind),
    .buf_rd_rst_o(buf_rd_rst), .resp_o      (resp),
    .resp_vld_o  (resp_vld),   .data_pid1_o (tx_pid1),
    .busy_o      (busy)
  );

  usb_pkt_buffer i_usb_pkt_buffer (
    .clock_i (clock_i),    .arst_n_i(arst_n_i),
    .we_i    (byte_we),    .data_i  (rx_byte),
    .commit_i(buf_commit), .rewind_i(buf_rewind),
    .rd_i    (buf_rd),     .rd_rst_i(buf_rd_rst),
    .empty_o (),           .count_o (buf_count),
    .data_o  (buf_data)
  );

  usb_tx_build i_usb_tx_build (
    .clock_i    (clock_i),     .arst_n_i   (arst_n_i),
    .resp_i     (resp),        .resp_vld_i (resp_vld),
    .data_pid1_i(tx_pid1),     .buf_count_i(buf_count),
    .buf_data_i (buf_data),    .tx_tready_i(tx_tready_i),
    .buf_rd_o   (buf_rd),      .resp_done_o(resp_done),
    .tx_tvalid_o(tx_tvalid_o), .tx_tlast_o (tx_tlast_o),
    .tx_tdata_o (tx_tdata_o)
  );

endmodule

/* bench/tb_usb_bulk.sv */
`timescale 1ns/1ps
`include "usb_defs.svh"
module tb_usb_bulk import usb_pkg::*; ();

  localparam int TIMEOUT = 400;  // Cycles any single wait may take

  logic       clock;
  logic       arst_n;
  logic       rx_tvalid, rx_tlast, rx_tready;
  logic [7:0] rx_tdata;
  logic       tx_tvalid, tx_tlast, tx_tready;
  logic [7:0] tx_tdata;

  integer     seed;
  int         checks, value_errs, other_errs;
  logic [7:0] payload [64];  // Next payload the host sends
  int         pay_len;
  logic [7:0] held [64];     // Payload the device should be holding
  int         held_len;
  logic [7:0] resp [80];
  int         resp_len;
  bit         out_tog, in_tog, in_sent;
  bit         rand_ready;

  usb_bulk_top i_usb_bulk_top (
    .clock_i    (clock),     .arst_n_i   (arst_n),
    .rx_tvalid_i(rx_tvalid), .rx_tlast_i (rx_tlast),
    .rx_tdata_i (rx_tdata),  .rx_tready_o(rx_tready),
    .tx_tvalid_o(tx_tvalid), .tx_tlast_o (tx_tlast),
    .tx_tdata_o (tx_tdata),  .tx_tready_i(tx_tready)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic finish_run();
    $display("Checks %0d, value errors %0d, other errors %0d", checks, value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  task automatic abort_run(input string why);
    other_errs++;
    $display("Error at %0t: %s", $time, why);
    finish_run();
  endtask

  task automatic check_pid(input string name, input usb_pid_e exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      value_errs++;
      $display("Fail %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      value_errs++;
      $display("Fail %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      value_errs++;
      $display("Fail %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      value_errs++;
      $display("Fail %0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  // Bit-serial CRC16 with the LSB first
  function automatic logic [15:0] crc_update(input logic [15:0] crc, input logic [7:0] b);
    logic [15:0] c;
    logic        fb;
    c = crc;
    for (int k = 0; k < 8; k++) begin
      fb = c[0] ^ b[k];
      c  = c >> 1;
      if (fb) c = c ^ 16'hA001;
    end
    return c;
  endfunction

  task automatic reset_dut();
    arst_n    = 1'b0;
    rx_tvalid = 1'b0;
    rx_tlast  = 1'b0;
    rx_tdata  = 8'h00;
    tx_tready = 1'b0;
    repeat (5) @(posedge clock);
    #2;
    arst_n   = 1'b1;
    out_tog  = 1'b0;
    in_tog   = 1'b0;
    in_sent  = 1'b0;
    held_len = 0;
  endtask

  // Ready is sampled at the falling edge and the byte moves on the next rising edge
  task automatic push_byte(input logic [7:0] data, input logic last);
    int wait_cnt;
    wait_cnt  = 0;
    rx_tvalid = 1'b1;
    rx_tdata  = data;
    rx_tlast  = last;
    @(negedge clock);
    while (!rx_tready) begin
      wait_cnt++;
      if (wait_cnt > TIMEOUT) abort_run("rx_tready_o stayed low, byte never accepted");
      @(negedge clock);
    end
    @(posedge clock);
    #2;
    rx_tvalid = 1'b0;
    rx_tlast  = 1'b0;
  endtask

  task automatic send_token(input usb_pid_e pid, input logic [6:0] addr, input logic [3:0] ep);
    push_byte(pid, 1'b0);
    push_byte({ep[0], addr}, 1'b0);
    push_byte({5'h00, ep[3:1]}, 1'b1);  // CRC5 field left at zero
  endtask

  task automatic send_data(input bit pid1, input bit corrupt);
    logic [15:0] crc;
    crc = 16'hFFFF;
    push_byte(pid1 ? PID_DATA1 : PID_DATA0, 1'b0);
    for (int i = 0; i < pay_len; i++) begin
      push_byte(payload[i], 1'b0);
      crc = crc_update(crc, payload[i]);
    end
    push_byte(~crc[7:0] ^ {7'd0, corrupt}, 1'b0);
    push_byte(~crc[15:8], 1'b1);
  endtask

  task automatic send_ack();
    push_byte(PID_ACK, 1'b1);
  endtask

  task automatic collect_resp();
    int idle;
    bit done;
    idle      = 0;
    done      = 1'b0;
    resp_len  = 0;
    tx_tready = rand_ready ? (($random(seed) % 3) != 0) : 1'b1;
    while (!done) begin
      @(negedge clock);
      if (tx_tvalid) begin
        check_bit("rx_tready_o", 1'b0, rx_tready);  // Host is held off while the device answers
      end
      if (tx_tvalid && tx_tready) begin
        if (resp_len >= 80) abort_run("tx stream ran past any legal packet length");
        resp[resp_len] = tx_tdata;
        resp_len++;
        done = tx_tlast;
      end else begin
        idle++;
        if (idle > TIMEOUT) abort_run("no complete response on the tx stream");
      end
      @(posedge clock);
      #2;
      tx_tready = rand_ready ? (($random(seed) % 3) != 0) : 1'b1;
    end
    tx_tready = 1'b0;
  endtask

  task automatic expect_silence();
    for (int i = 0; i < 40; i++) begin
      @(negedge clock);
      if (tx_tvalid) begin
        other_errs++;
        $display("Error at %0t: device answered a packet it should ignore", $time);
        break;
      end
    end
    @(posedge clock);
    #2;
  endtask

  task automatic check_handshake(input usb_pid_e exp);
    check_count("response length", 1, resp_len);
    check_pid("tx_tdata_o pid", exp, resp[0]);
  endtask

  task automatic check_data_resp(input usb_pid_e exp);
    logic [15:0] crc;
    crc = 16'hFFFF;
    check_count("response length", held_len + 3, resp_len);
    if (resp_len == held_len + 3) begin
      check_pid("tx_tdata_o pid", exp, resp[0]);
      for (int i = 0; i < held_len; i++) begin
        check_byte($sformatf("tx_tdata_o byte %0d", i + 1), held[i], resp[i + 1]);
        crc = crc_update(crc, held[i]);
      end
      check_byte("tx_tdata_o crc low", ~crc[7:0], resp[held_len + 1]);
      check_byte("tx_tdata_o crc high", ~crc[15:8], resp[held_len + 2]);
    end
  endtask

  task automatic gen_payload(input int n);
    for (int i = 0; i < n; i++) payload[i] = $random(seed);
    pay_len = n;
  endtask

  // Model of the OUT rules where a retry gets ACK and a held packet gets NAK
  task automatic out_transaction(input bit pid1);
    usb_pid_e exp;
    in_sent = 1'b0;
    if (pid1 != out_tog) begin
      exp = PID_ACK;
    end else if (held_len != 0) begin
      exp = PID_NAK;
    end else begin
      exp = PID_ACK;
      for (int i = 0; i < pay_len; i++) held[i] = payload[i];
      held_len = pay_len;
      out_tog  = ~out_tog;
    end
    send_token(PID_OUT, `USB_DEV_ADDR, `USB_EP_NUM);
    send_data(pid1, 1'b0);
    collect_resp();
    check_handshake(exp);
  endtask

  task automatic in_transaction();
    send_token(PID_IN, `USB_DEV_ADDR, `USB_EP_NUM);
    collect_resp();
    if (held_len == 0) begin
      check_handshake(PID_NAK);
    end else begin
      check_data_resp(in_tog ? PID_DATA1 : PID_DATA0);
    end
    in_sent = (held_len != 0);
  endtask

  task automatic ack_transaction();
    send_ack();
    if (in_sent) begin  // Host took the data
      in_tog   = ~in_tog;
      held_len = 0;
      in_sent  = 1'b0;
    end
  endtask

  task automatic loopback_16();
    reset_dut();
    gen_payload(16);
    out_transaction(1'b0);
    in_transaction();
    ack_transaction();
  endtask

  task automatic nak_and_bad_crc();
    reset_dut();
    in_transaction();
    gen_payload(8);
    send_token(PID_OUT, `USB_DEV_ADDR, `USB_EP_NUM);
    send_data(out_tog, 1'b1);
    expect_silence();
    in_transaction();
  endtask

  task automatic foreign_tokens();
    gen_payload(8);
    send_token(PID_OUT, `USB_DEV_ADDR ^ 7'h01, `USB_EP_NUM);
    send_data(out_tog, 1'b0);
    expect_silence();
    send_token(PID_IN, `USB_DEV_ADDR, `USB_EP_NUM ^ 4'h2);
    expect_silence();
    in_transaction();  // Still empty
  endtask

  task automatic repeated_out();
    reset_dut();
    gen_payload(16);
    out_transaction(1'b0);
    out_transaction(1'b0);
    in_transaction();
    in_transaction();  // Resend without ACK
    ack_transaction();
    gen_payload(16);
    out_transaction(1'b1);
    in_transaction();
    ack_transaction();
  endtask

  task automatic full_buffer_nak();
    reset_dut();
    gen_payload(12);
    out_transaction(1'b0);
    gen_payload(12);
    out_transaction(1'b1);
    in_transaction();
    ack_transaction();
  endtask

  task automatic stalled_64_bytes();
    reset_dut();
    gen_payload(64);
    out_transaction(1'b0);
    rand_ready = 1'b1;
    in_transaction();
    rand_ready = 1'b0;
    ack_transaction();
  endtask

  initial begin
    seed       = 32'h6fcb;
    checks     = 0;
    value_errs = 0;
    other_errs = 0;
    rand_ready = 1'b0;
    loopback_16();
    nak_and_bad_crc();
    foreign_tokens();
    repeated_out();
    full_buffer_nak();
    stalled_64_bytes();
    finish_run();
  end

endmodule

/* all.f */
+incdir+common
common/usb_pkg.sv
logic/usb_crc16.sv
decode/usb_pkt_decode.sv
execute/usb_ep_ctrl.sv
logic/usb_pkt_buffer.sv
result/usb_tx_build.sv
logic/usb_bulk_top.sv
bench/tb_usb_bulk.sv

/* Bender.yml */
package:
  name: usb_bulk_loopback

export_include_dirs:
  - common

sources:
  - files:
      - common/usb_pkg.sv
      - logic/usb_crc16.sv
      - decode/usb_pkt_decode.sv
      - execute/usb_ep_ctrl.sv
      - logic/usb_pkt_buffer.sv
      - result/usb_tx_build.sv
      - logic/usb_bulk_top.sv
  - target: test
    files:
      - bench/tb_usb_bulk.sv
